// ==== src.f ====
design/pipe_pkg.sv
design/pipe_ifs.sv
design/decode_stage.sv
design/scoreboard.sv
design/execute_stage.sv
design/writeback_regfile.sv
design/pipeline_top.sv
test/tb_clock_gen.sv
test/pipeline_tb.sv

// ==== test/pipeline_tb.sv ====
/*
 * Pipeline testbench
 * applies a table of instructions and stall levels, keeps a
 * register model of accepted instructions and compares registers
 */
`timescale 1ns/1ps

module pipeline_tb;
   import pipe_pkg::*;

   localparam int DRIVE_DLY  = 1;
   localparam int WAIT_LIMIT = 50;
   localparam int NUM_RAND   = 48;

   typedef struct packed {
      inst_t inst;
      logic  valid;
      logic  stallex;
      logic  stallwb;
   } stim_t;

   logic     clk;
   logic     rst;
   inst_t    inst;
   logic     inst_valid;
   logic     stallex;
   logic     stallwb;
   reg_idx_t rd_sel;
   logic     inst_ready;
   data_t    rd_data;

   stim_t      stim_q [$];
   int         phase_end [4];
   logic [3:0] set_imm [NUM_REGS];
   data_t      model [NUM_REGS];
   data_t      exp_regs [NUM_REGS];
   integer     seed;

   tb_clock_gen clk_gen (
      .clk (clk),
      .rst (rst)
   );

   pipeline_top dut0 (
      .clk        (clk),
      .rst        (rst),
      .inst       (inst),
      .inst_valid (inst_valid),
      .stallex    (stallex),
      .stallwb    (stallwb),
      .rd_sel     (rd_sel),
      .inst_ready (inst_ready),
      .rd_data    (rd_data)
   );

   // ----------------------------------------
   // failure handling and compares
   task automatic stop_on_failure();
      $display("Checks failed");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic timeout_fail(string what);
      $display("timed out waiting: %s", what);
      stop_on_failure();
   endtask

   task automatic check_data(data_t got, data_t exp, string what);
      if (got !== exp) begin
         $display("ERR @%0t: %s got %02h expected %02h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   task automatic check_ready(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   // ----------------------------------------
   // reference model
   function automatic void model_step(inst_t i);
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      rs1 = i[5:4];
      rs2 = i[3:2];
      rd  = i[1:0];
      case (i[7:6])
         2'd1: model[rd] = model[rs1] + model[rs2];
         2'd2: model[rd] = {4'b0000, i[5:2]};
         2'd3: model[rd] = ~(model[rs1] & model[rs2]);
         default: ;
      endcase
   endfunction

   task automatic copy_model();
      for (int r = 0; r < NUM_REGS; r++) begin
         exp_regs[r] = model[r];
      end
   endtask

   // ----------------------------------------
   // stimulus table
   function automatic inst_t enc(op_t op, reg_idx_t a, reg_idx_t b, reg_idx_t d);
      return {op, a, b, d};
   endfunction

   function automatic inst_t enc_set(logic [3:0] imm, reg_idx_t d);
      return {op_set, imm, d};
   endfunction

   task automatic push_entry(inst_t i, logic v, logic sx, logic sw);
      stim_t e;
      e.inst    = i;
      e.valid   = v;
      e.stallex = sx;
      e.stallwb = sw;
      stim_q.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] rnd;
      set_imm[0] = 4'd5;
      set_imm[1] = 4'd3;
      set_imm[2] = 4'd12;
      set_imm[3] = 4'd9;
      for (int r = 0; r < NUM_REGS; r++) begin
         push_entry(enc_set(set_imm[r], reg_idx_t'(r)), 1'b1, 1'b0, 1'b0);
      end
      phase_end[0] = stim_q.size();

      // sources in execute and writeback at the same time
      push_entry(enc(op_add, 2'd0, 2'd1, 2'd2), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_nand, 2'd2, 2'd1, 2'd3), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_add, 2'd3, 2'd2, 2'd0), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_add, 2'd0, 2'd0, 2'd1), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_nand, 2'd1, 2'd3, 2'd2), 1'b1, 1'b0, 1'b0);
      push_entry(enc_set(4'd7, 2'd3), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_add, 2'd3, 2'd3, 2'd0), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_nand, 2'd0, 2'd3, 2'd0), 1'b1, 1'b0, 1'b0);
      phase_end[1] = stim_q.size();

      push_entry(enc(op_nop, 2'd1, 2'd2, 2'd3), 1'b1, 1'b0, 1'b0);
      push_entry(enc(op_nop, 2'd3, 2'd3, 2'd0), 1'b1, 1'b0, 1'b1);
      push_entry(8'h00, 1'b1, 1'b1, 1'b0);
      phase_end[2] = stim_q.size();

      // mixed ops with random valid and stall levels
      for (int n = 0; n < NUM_RAND; n++) begin
         rnd = $random(seed);
         push_entry(rnd[7:0], rnd[10:8] != 3'd0, rnd[13:12] == 2'd0,
                    rnd[17:16] == 2'd0);
      end
      phase_end[3] = stim_q.size();
   endtask

   // ----------------------------------------
   // drive and drain
   // entered and left a short delay after a rising edge
   task automatic apply_entry(stim_t e);
      logic taken;
      inst       = e.inst;
      inst_valid = e.valid;
      stallex    = e.stallex;
      stallwb    = e.stallwb;
      @(negedge clk);
      taken = inst_valid && inst_ready;
      @(posedge clk);
      if (taken) begin
         model_step(e.inst);
      end
      #DRIVE_DLY;
   endtask

   task automatic apply_range(int lo, int hi);
      for (int n = lo; n < hi; n++) begin
         apply_entry(stim_q[n]);
      end
   endtask

   task automatic drain();
      int cnt;
      inst_valid = 1'b0;
      stallex    = 1'b0;
      stallwb    = 1'b0;
      cnt        = 0;
      @(negedge clk);
      while (inst_ready !== 1'b1 && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         timeout_fail("inst_ready while draining");
      end
      // three edges empty a three-stage pipe with no stalls
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic check_regs(string tag);
      for (int r = 0; r < NUM_REGS; r++) begin
         rd_sel = reg_idx_t'(r);
         @(negedge clk);
         check_data(rd_data, exp_regs[r], $sformatf("%s r%0d", tag, r));
         @(posedge clk);
         #DRIVE_DLY;
      end
   endtask

   // set to r2, counted from its accepting edge
   task automatic check_latency();
      data_t old_val;
      data_t new_val;
      inst_t i;
      int    cnt;
      old_val    = model[2];
      new_val    = {4'b0000, old_val[3:0] + 4'd1};
      i          = enc_set(new_val[3:0], 2'd2);
      rd_sel     = 2'd2;
      inst       = i;
      inst_valid = 1'b1;
      cnt        = 0;
      @(negedge clk);
      while (inst_ready !== 1'b1 && cnt < WAIT_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         timeout_fail("acceptance of the latency set");
      end
      @(posedge clk);
      model_step(i);
      #DRIVE_DLY;
      inst_valid = 1'b0;
      check_data(rd_data, old_val, "rd_data after accepting edge");
      @(posedge clk);
      #DRIVE_DLY;
      check_data(rd_data, old_val, "rd_data after second edge");
      @(posedge clk);
      #DRIVE_DLY;
      check_data(rd_data, new_val, "rd_data after third edge");
   endtask

   // ----------------------------------------
   // main sequence
   initial begin
      int cnt;
      inst       = '0;
      inst_valid = 1'b0;
      stallex    = 1'b0;
      stallwb    = 1'b0;
      rd_sel     = '0;
      seed       = 32'h52bc;
      build_table();

      cnt = 0;
      while (rst !== 1'b0 && cnt < WAIT_LIMIT) begin
         @(posedge clk);
         cnt++;
      end
      if (cnt >= WAIT_LIMIT) begin
         timeout_fail("reset release");
      end
      #DRIVE_DLY;
      @(negedge clk);
      check_ready(inst_ready, 1'b1, "inst_ready after reset");
      @(posedge clk);
      #DRIVE_DLY;

      apply_range(0, phase_end[0]);
      drain();
      for (int r = 0; r < NUM_REGS; r++) begin
         exp_regs[r] = {4'b0000, set_imm[r]};
      end
      check_regs("set");

      check_latency();
      drain();

      apply_range(phase_end[0], phase_end[1]);
      drain();
      copy_model();
      check_regs("dependent chain");

      // registers before the nops are the expected values
      apply_range(phase_end[1], phase_end[2]);
      drain();
      check_regs("nop");

      apply_range(phase_end[2], phase_end[3]);
      drain();
      copy_model();
      check_regs("random stall");

      $display("All checks passed");
      $finish;
   end

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 40 ns clock, reset held high for the first two cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst
);
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// ==== design/pipeline_top.sv ====
/*
 * Pipeline top
 * decode, execute and writeback with scoreboard forwarding;
 * plain ports for the instruction stream, stalls and debug read
 */
`timescale 1ns/1ps

module pipeline_top (
   input  logic               clk,
   input  logic               rst,
   input  pipe_pkg::inst_t    inst,
   input  logic               inst_valid,
   input  logic               stallex,
   input  logic               stallwb,
   input  pipe_pkg::reg_idx_t rd_sel,
   output logic               inst_ready,
   output pipe_pkg::data_t    rd_data
);
   import pipe_pkg::*;

   logic     id_go;
   logic     id_wen;
   reg_idx_t id_rd;
   reg_idx_t rs1_idx;
   reg_idx_t rs2_idx;
   data_t    fwd_op1;
   data_t    fwd_op2;

   logic     ex_go;
   data_t    ex_val;

   logic     wb_go;
   data_t    wb_val;
   data_t    rf_rs1;
   data_t    rf_rs2;

   // ----------------------------------------
   // stage registers
   id_ex_if id_ex ();
   ex_wb_if ex_wb ();

   decode_stage u_decode (
      .clk        (clk),
      .rst        (rst),
      .inst       (inst),
      .inst_valid (inst_valid),
      .fwd_op1    (fwd_op1),
      .fwd_op2    (fwd_op2),
      .inst_ready (inst_ready),
      .id_go      (id_go),
      .id_wen     (id_wen),
      .rs1_idx    (rs1_idx),
      .rs2_idx    (rs2_idx),
      .id_rd      (id_rd),
      .id_ex      (id_ex.producer)
   );

   scoreboard u_scoreboard (
      .clk     (clk),
      .rst     (rst),
      .id_go   (id_go),
      .id_wen  (id_wen),
      .id_rd   (id_rd),
      .rs1_idx (rs1_idx),
      .rs2_idx (rs2_idx),
      .ex_go   (ex_go),
      .wb_go   (wb_go),
      .rf_rs1  (rf_rs1),
      .rf_rs2  (rf_rs2),
      .ex_val  (ex_val),
      .wb_val  (wb_val),
      .id_ex   (id_ex.observer),
      .ex_wb   (ex_wb.observer),
      .fwd_op1 (fwd_op1),
      .fwd_op2 (fwd_op2)
   );

   execute_stage u_execute (
      .clk     (clk),
      .rst     (rst),
      .stallex (stallex),
      .id_ex   (id_ex.consumer),
      .ex_wb   (ex_wb.producer),
      .ex_go   (ex_go),
      .ex_val  (ex_val)
   );

   writeback_regfile u_writeback (
      .clk     (clk),
      .stallwb (stallwb),
      .rs1_idx (rs1_idx),
      .rs2_idx (rs2_idx),
      .rd_sel  (rd_sel),
      .ex_wb   (ex_wb.consumer),
      .wb_go   (wb_go),
      .rf_rs1  (rf_rs1),
      .rf_rs2  (rf_rs2),
      .wb_val  (wb_val),
      .rd_data (rd_data)
   );

endmodule

// ==== design/writeback_regfile.sv ====
/*
 * Writeback and register file
 * four 8-bit registers written on wb_go, two source read
 * ports for decode and a debug read port
 */
`timescale 1ns/1ps

module writeback_regfile (
   input  logic               clk,
   input  logic               stallwb,
   input  pipe_pkg::reg_idx_t rs1_idx,
   input  pipe_pkg::reg_idx_t rs2_idx,
   input  pipe_pkg::reg_idx_t rd_sel,
   ex_wb_if.consumer          ex_wb,
   output logic               wb_go,
   output pipe_pkg::data_t    rf_rs1,
   output pipe_pkg::data_t    rf_rs2,
   output pipe_pkg::data_t    wb_val,
   output pipe_pkg::data_t    rd_data
);
   import pipe_pkg::*;

   data_t regs [NUM_REGS];

   // ----------------------------------------
   // control
   assign ex_wb.wb_ready = !stallwb;
   assign wb_go          = ex_wb.valid && ex_wb.wb_ready;

   // forwarded to decode while still pending
   assign wb_val = ex_wb.val;

   // ----------------------------------------
   // register file
   always_ff @(posedge clk) begin
      if (wb_go && ex_wb.reg_wen) begin
         regs[ex_wb.rd] <= ex_wb.val;
      end
   end

   assign rf_rs1  = regs[rs1_idx];
   assign rf_rs2  = regs[rs2_idx];
   // debug read
   assign rd_data = regs[rd_sel];

endmodule

// ==== design/execute_stage.sv ====
/*
 * Execute stage
 * ALU for add, set and nand, and the execute-to-writeback
 * register with its stall
 */
`timescale 1ns/1ps

module execute_stage (
   input  logic            clk,
   input  logic            rst,
   input  logic            stallex,
   id_ex_if.consumer       id_ex,
   ex_wb_if.producer       ex_wb,
   output logic            ex_go,
   output pipe_pkg::data_t ex_val
);
   import pipe_pkg::*;

   data_t alu_res;

   // ----------------------------------------
   // ALU
   always_comb begin
      case (id_ex.op)
         op_add:  alu_res = id_ex.operand1 + id_ex.operand2;
         op_set:  alu_res = id_ex.operand1;
         op_nand: alu_res = ~(id_ex.operand1 & id_ex.operand2);
         default: alu_res = '0;
      endcase
   end

   // also the forwarding value for decode
   assign ex_val = alu_res;

   // ----------------------------------------
   // control
   assign id_ex.ex_ready = !stallex && (ex_wb.wb_ready || !ex_wb.valid);
   assign ex_go          = id_ex.valid && id_ex.ex_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         ex_wb.valid <= 1'b0;
      end else if (ex_go) begin
         ex_wb.valid <= 1'b1;
      end else if (ex_wb.wb_ready) begin
         ex_wb.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_go) begin
         ex_wb.val     <= alu_res;
         ex_wb.rd      <= id_ex.rd;
         ex_wb.reg_wen <= id_ex.reg_wen;
      end
   end

endmodule

// ==== design/scoreboard.sv ====
/*
 * Scoreboard
 * tracks per register whether a result is pending in
 * execute or writeback, and selects forwarded operands
 */
`timescale 1ns/1ps

module scoreboard (
   input  logic               clk,
   input  logic               rst,
   input  logic               id_go,
   input  logic               id_wen,
   input  pipe_pkg::reg_idx_t id_rd,
   input  pipe_pkg::reg_idx_t rs1_idx,
   input  pipe_pkg::reg_idx_t rs2_idx,
   input  logic               ex_go,
   input  logic               wb_go,
   input  pipe_pkg::data_t    rf_rs1,
   input  pipe_pkg::data_t    rf_rs2,
   input  pipe_pkg::data_t    ex_val,
   input  pipe_pkg::data_t    wb_val,
   id_ex_if.observer          id_ex,
   ex_wb_if.observer          ex_wb,
   output pipe_pkg::data_t    fwd_op1,
   output pipe_pkg::data_t    fwd_op2
);
   import pipe_pkg::*;

   sb_loc_t sb [NUM_REGS];
   logic    ex_wen;
   logic    wb_done;

   // result leaving execute for writeback
   assign ex_wen  = id_ex.valid && id_ex.reg_wen;
   // result being written this cycle
   assign wb_done = wb_go && ex_wb.valid && ex_wb.reg_wen;

   // ----------------------------------------
   // entry update
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            sb[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            if (id_go) begin
               sb[i][SB_EX_BIT] <= id_wen && (id_rd == reg_idx_t'(i));
            end else if (ex_go) begin
               sb[i][SB_EX_BIT] <= 1'b0;
            end

            if (ex_go) begin
               sb[i][SB_WB_BIT] <= ex_wen && (id_ex.rd == reg_idx_t'(i));
            end else if (wb_done && (ex_wb.rd == reg_idx_t'(i))) begin
               sb[i][SB_WB_BIT] <= 1'b0;
            end
         end
      end
   end

   // ----------------------------------------
   // operand select
   // the execute copy is the youngest, so it wins over writeback
   function automatic data_t sel_operand(sb_loc_t loc, data_t rf_val,
                                         data_t ex_fwd, data_t wb_fwd);
      data_t res;
      if (loc == '0) begin
         res = rf_val;
      end else if (!loc[SB_EX_BIT]) begin
         res = wb_fwd;
      end else begin
         res = ex_fwd;
      end
      return res;
   endfunction

   assign fwd_op1 = sel_operand(sb[rs1_idx], rf_rs1, ex_val, wb_val);
   assign fwd_op2 = sel_operand(sb[rs2_idx], rf_rs2, ex_val, wb_val);

endmodule

// ==== design/decode_stage.sv ====
/*
 * Decode stage
 * splits the instruction, picks operands from the forwarding
 * network and holds the decode-to-execute register
 */
`timescale 1ns/1ps

module decode_stage (
   input  logic              clk,
   input  logic              rst,
   input  pipe_pkg::inst_t   inst,
   input  logic              inst_valid,
   input  pipe_pkg::data_t   fwd_op1,
   input  pipe_pkg::data_t   fwd_op2,
   output logic              inst_ready,
   output logic              id_go,
   output logic              id_wen,
   output pipe_pkg::reg_idx_t rs1_idx,
   output pipe_pkg::reg_idx_t rs2_idx,
   output pipe_pkg::reg_idx_t id_rd,
   id_ex_if.producer         id_ex
);
   import pipe_pkg::*;

   op_t   op;
   logic [IMM_WIDTH-1:0] imm;
   data_t operand1;
   data_t operand2;

   // ----------------------------------------
   // field split
   assign op      = op_t'(inst[OP_MSB -: OP_W]);
   assign rs1_idx = inst[RS1_MSB -: IDX_W];
   assign rs2_idx = inst[RS2_MSB -: IDX_W];
   assign id_rd   = inst[RD_MSB -: IDX_W];
   assign imm     = inst[RS1_MSB -: IMM_WIDTH];

   // everything but nop writes rd
   assign id_wen = (op != op_nop);

   // set takes the zero-extended immediate
   assign operand1 = (op == op_set) ? data_t'(imm) : fwd_op1;
   assign operand2 = fwd_op2;

   // ----------------------------------------
   // interlock
   assign inst_ready = id_ex.ex_ready || !id_ex.valid;
   assign id_go      = inst_valid && inst_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         id_ex.valid <= 1'b0;
      end else if (id_go) begin
         id_ex.valid <= 1'b1;
      end else if (id_ex.ex_ready) begin
         // execute took the entry, nothing behind it
         id_ex.valid <= 1'b0;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (id_go) begin
         id_ex.op       <= op;
         id_ex.rd       <= id_rd;
         id_ex.reg_wen  <= id_wen;
         id_ex.operand1 <= operand1;
         id_ex.operand2 <= operand2;
      end
   end

endmodule

// ==== design/pipe_ifs.sv ====
/*
 * Stage register interfaces
 * id_ex_if and ex_wb_if carry the pipeline registers
 * between stages, plus the ready coming back upstream
 */
`timescale 1ns/1ps

interface id_ex_if;
   import pipe_pkg::*;

   logic  valid;
   op_t   op;
   reg_idx_t rd;
   logic  reg_wen;
   data_t operand1;
   data_t operand2;
   logic  ex_ready;

   modport producer (output valid, op, rd, reg_wen, operand1, operand2,
                     input ex_ready);
   modport consumer (input valid, op, rd, reg_wen, operand1, operand2,
                     output ex_ready);
   // scoreboard only needs the destination
   modport observer (input valid, reg_wen, rd);
endinterface

interface ex_wb_if;
   import pipe_pkg::*;

   logic     valid;
   data_t    val;
   reg_idx_t rd;
   logic     reg_wen;
   logic     wb_ready;

   modport producer (output valid, val, rd, reg_wen,
                     input wb_ready);
   modport consumer (input valid, val, rd, reg_wen,
                     output wb_ready);
   modport observer (input valid, reg_wen, rd);
endinterface

// ==== design/pipe_pkg.sv ====
/*
 * Pipeline package
 * widths, value types, opcode encoding and instruction
 * field positions shared by the three-stage pipeline
 */
package pipe_pkg;

   // ----------------------------------------
   // widths
   localparam int DATA_W    = 8;
   localparam int IDX_W     = 2;
   localparam int INST_W    = 8;
   localparam int OP_W      = 2;
   localparam int IMM_WIDTH = 4;
   localparam int NUM_REGS  = 4;

   // ----------------------------------------
   // instruction fields, msb of each
   // set uses bits 5..2 as its immediate
   localparam int OP_MSB  = 7;
   localparam int RS1_MSB = 5;
   localparam int RS2_MSB = 3;
   localparam int RD_MSB  = 1;

   // scoreboard entry bits
   localparam int SB_EX_BIT = 1;
   localparam int SB_WB_BIT = 0;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [IDX_W-1:0]  reg_idx_t;
   typedef logic [INST_W-1:0] inst_t;

   // pending location, ex in the upper bit, wb in the lower
   typedef logic [1:0] sb_loc_t;

   typedef enum logic [OP_W-1:0] {
      op_nop  = 2'd0,
      op_add  = 2'd1,
      op_set  = 2'd2,
      op_nand = 2'd3
   } op_t;

endpackage
